/* Makefile */
# Verilator flow for the gomoku board evaluator

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tb_board_evaluator
RTL_TOP   ?= board_evaluator_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR)

# status comes from grep, so a missing pass line fails the target
sim: build
	$(OBJ_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* hw/board_evaluator_top.sv */
// gomoku position evaluator top level, connects the sequencer to the line scoring pipeline
`timescale 1ns/1ps
`default_nettype none

module board_evaluator_top #(
    parameter gomoku_pkg::score_t W_FIVE         = gomoku_pkg::DEF_W_FIVE,
    parameter gomoku_pkg::score_t W_OPEN_FOUR    = gomoku_pkg::DEF_W_OPEN_FOUR,
    parameter gomoku_pkg::score_t W_BLOCKED_FOUR = gomoku_pkg::DEF_W_BLOCKED_FOUR,
    parameter gomoku_pkg::score_t W_OPEN_THREE   = gomoku_pkg::DEF_W_OPEN_THREE
) (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,
    input  wire logic                start_i,
    input  wire gomoku_pkg::board_t  board_i,
    input  wire logic                turn_i,
    output logic                     busy_o,
    output logic                     done_o,
    output gomoku_pkg::score_t       score_o
);

    logic                  load;
    logic                  issue;
    gomoku_pkg::dir_t      dir;
    gomoku_pkg::line_idx_t idx;
    logic                  last;
    logic                  side;
    logic                  line_valid;
    logic                  line_last;
    gomoku_pkg::line_t     line;

    score_if sif ();

    scan_controller u_ctrl (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .start_i (start_i),
        .turn_i  (turn_i),
        .done_i  (done_o),
        .busy_o  (busy_o),
        .load_o  (load),
        .issue_o (issue),
        .dir_o   (dir),
        .idx_o   (idx),
        .last_o  (last),
        .side_o  (side)
    );

    board_line_reader u_reader (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .board_i      (board_i),
        .load_i       (load),
        .issue_i      (issue),
        .dir_i        (dir),
        .idx_i        (idx),
        .last_i       (last),
        .line_valid_o (line_valid),
        .line_last_o  (line_last),
        .line_o       (line)
    );

    line_pattern_matcher #(
        .W_FIVE         (W_FIVE),
        .W_OPEN_FOUR    (W_OPEN_FOUR),
        .W_BLOCKED_FOUR (W_BLOCKED_FOUR),
        .W_OPEN_THREE   (W_OPEN_THREE)
    ) u_match (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .line_valid_i (line_valid),
        .line_last_i  (line_last),
        .line_i       (line),
        .sif          (sif.matcher_mp)
    );

    score_accumulator u_accum (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .load_i  (load),
        .side_i  (side),
        .sif     (sif.accum_mp),
        .done_o  (done_o),
        .score_o (score_o)
    );

endmodule

`default_nettype wire

/* hw/board_line_reader.sv */
// board capture and line extraction, one border-padded line per cycle for a direction and index
`timescale 1ns/1ps
`default_nettype none

module board_line_reader (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire gomoku_pkg::board_t    board_i,
    input  wire logic                  load_i,
    input  wire logic                  issue_i,
    input  wire gomoku_pkg::dir_t      dir_i,
    input  wire gomoku_pkg::line_idx_t idx_i,
    input  wire logic                  last_i,
    output logic                       line_valid_o,
    output logic                       line_last_o,
    output gomoku_pkg::line_t          line_o
);

    localparam int N = gomoku_pkg::BOARD_SIZE;

    gomoku_pkg::board_t board_r;
    gomoku_pkg::line_t  line_d;

    always_ff @(posedge i_clk) begin
        if (load_i) begin
            board_r <= board_i;
        end
    end

    always_comb begin
        int d;
        int r0;
        int c0;
        int r;
        int c;
        int k;

        d  = int'(idx_i);
        r0 = 0;
        c0 = 0;
        r  = 0;
        c  = 0;
        // start cell of the diagonal
        case (dir_i)
            gomoku_pkg::DIR_DIAG_DOWN_RIGHT: begin
                r0 = (d < N - 1) ? (N - 1 - d) : 0;
                c0 = (d > N - 1) ? (d - (N - 1)) : 0;
            end
            gomoku_pkg::DIR_DIAG_DOWN_LEFT: begin
                r0 = (d > N - 1) ? (d - (N - 1)) : 0;
                c0 = (d < N - 1) ? d : (N - 1);
            end
            default: begin
                r0 = 0;
                c0 = 0;
            end
        endcase

        for (int p = 0; p < gomoku_pkg::LINE_CELLS; p++) begin
            k = p - 1;
            case (dir_i)
                gomoku_pkg::DIR_ROW: begin
                    r = d;
                    c = k;
                end
                gomoku_pkg::DIR_COL: begin
                    r = k;
                    c = d;
                end
                gomoku_pkg::DIR_DIAG_DOWN_RIGHT: begin
                    r = r0 + k;
                    c = c0 + k;
                end
                default: begin
                    r = r0 + k;
                    c = c0 - k;
                end
            endcase
            // end cells and anything off the board read as border
            if (p == 0 || p == gomoku_pkg::LINE_CELLS - 1 || r < 0 || r > N - 1 ||
                c < 0 || c > N - 1) begin
                line_d[p] = gomoku_pkg::CELL_BORDER;
            end else begin
                line_d[p] = board_r[r * N + c];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            line_valid_o <= 1'b0;
            line_last_o  <= 1'b0;
        end else begin
            line_valid_o <= issue_i;
            line_last_o  <= issue_i && last_i;
        end
    end

    always_ff @(posedge i_clk) begin
        line_o <= line_d;
    end

endmodule

`default_nettype wire

/* hw/gomoku_pkg.sv */
// gomoku evaluator types, board geometry and default pattern weights, referenced by scoped name
`default_nettype none

package gomoku_pkg;

    // board edge and padded line geometry
    localparam int BOARD_SIZE = 15;
    localparam int BOARD_CELLS = BOARD_SIZE * BOARD_SIZE;
    localparam int LINE_CELLS = BOARD_SIZE + 2;

    // rows, columns and both diagonal directions
    localparam int DIAG_COUNT = 2 * BOARD_SIZE - 1;
    localparam int LINE_COUNT = 2 * BOARD_SIZE + 2 * DIAG_COUNT;

    typedef enum logic [1:0] {
        CELL_BLACK  = 2'd0,
        CELL_WHITE  = 2'd1,
        CELL_EMPTY  = 2'd2,
        // only used to pad lines, never stored on the board
        CELL_BORDER = 2'd3
    } cell_t;

    // row-major, index 0 is the top-left cell
    typedef cell_t [BOARD_CELLS-1:0] board_t;

    // position 0 and LINE_CELLS-1 are always border
    typedef cell_t [LINE_CELLS-1:0] line_t;

    typedef enum logic [1:0] {
        DIR_ROW,
        DIR_COL,
        DIR_DIAG_DOWN_RIGHT,
        DIR_DIAG_DOWN_LEFT
    } dir_t;

    typedef logic [4:0] line_idx_t;

    typedef logic signed [31:0] score_t;

    // default weights per pattern class
    localparam score_t DEF_W_FIVE         = 32'sd1_000_000;
    localparam score_t DEF_W_OPEN_FOUR    = 32'sd100_000;
    localparam score_t DEF_W_BLOCKED_FOUR = 32'sd10_000;
    localparam score_t DEF_W_OPEN_THREE   = 32'sd1_000;

endpackage

`default_nettype wire

/* hw/line_pattern_matcher.sv */
// window pattern matcher producing weighted black and white scores for one line per cycle
`timescale 1ns/1ps
`default_nettype none

module line_pattern_matcher #(
    parameter gomoku_pkg::score_t W_FIVE         = gomoku_pkg::DEF_W_FIVE,
    parameter gomoku_pkg::score_t W_OPEN_FOUR    = gomoku_pkg::DEF_W_OPEN_FOUR,
    parameter gomoku_pkg::score_t W_BLOCKED_FOUR = gomoku_pkg::DEF_W_BLOCKED_FOUR,
    parameter gomoku_pkg::score_t W_OPEN_THREE   = gomoku_pkg::DEF_W_OPEN_THREE
) (
    input  wire logic               i_clk,
    input  wire logic               i_rst_n,
    input  wire logic               line_valid_i,
    input  wire logic               line_last_i,
    input  wire gomoku_pkg::line_t  line_i,
    score_if.matcher_mp             sif
);

    localparam int L = gomoku_pkg::LINE_CELLS;

    // opponent stone or the padding both close off a four
    function automatic logic is_blocker(
        input gomoku_pkg::cell_t cv,
        input gomoku_pkg::cell_t o
    );
        return (cv == o) || (cv == gomoku_pkg::CELL_BORDER);
    endfunction

    function automatic gomoku_pkg::score_t colour_score(
        input gomoku_pkg::line_t ln,
        input gomoku_pkg::cell_t c,
        input gomoku_pkg::cell_t o
    );
        gomoku_pkg::score_t sum;
        logic               mid_three;
        logic               mid_four;
        logic               head_empty;
        logic               tail_empty;

        sum = '0;
        // five-cell windows
        for (int s = 0; s + 5 <= L; s++) begin
            mid_three  = (ln[s+1] == c) && (ln[s+2] == c) && (ln[s+3] == c);
            head_empty = (ln[s] == gomoku_pkg::CELL_EMPTY);
            tail_empty = (ln[s+4] == gomoku_pkg::CELL_EMPTY);
            if (mid_three && ln[s] == c && ln[s+4] == c) begin
                sum = sum + W_FIVE;
            end
            if (mid_three && head_empty && tail_empty) begin
                sum = sum + W_OPEN_THREE;
            end
        end
        // six-cell windows
        for (int s = 0; s + 6 <= L; s++) begin
            mid_four   = (ln[s+1] == c) && (ln[s+2] == c) && (ln[s+3] == c) &&
                         (ln[s+4] == c);
            head_empty = (ln[s] == gomoku_pkg::CELL_EMPTY);
            tail_empty = (ln[s+5] == gomoku_pkg::CELL_EMPTY);
            if (mid_four && head_empty && tail_empty) begin
                sum = sum + W_OPEN_FOUR;
            end
            if (mid_four && ((head_empty && is_blocker(ln[s+5], o)) ||
                             (tail_empty && is_blocker(ln[s], o)))) begin
                sum = sum + W_BLOCKED_FOUR;
            end
        end
        return sum;
    endfunction

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            sif.valid <= 1'b0;
            sif.last  <= 1'b0;
        end else begin
            sif.valid <= line_valid_i;
            sif.last  <= line_valid_i && line_last_i;
        end
    end

    always_ff @(posedge i_clk) begin
        sif.black_score <= colour_score(line_i, gomoku_pkg::CELL_BLACK, gomoku_pkg::CELL_WHITE);
        sif.white_score <= colour_score(line_i, gomoku_pkg::CELL_WHITE, gomoku_pkg::CELL_BLACK);
    end

endmodule

`default_nettype wire

/* hw/scan_controller.sv */
// evaluation sequencer: accepts start, latches side to move and walks every line of the board
`timescale 1ns/1ps
`default_nettype none

module scan_controller (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  start_i,
    input  wire logic                  turn_i,
    input  wire logic                  done_i,
    output logic                       busy_o,
    output logic                       load_o,
    output logic                       issue_o,
    output gomoku_pkg::dir_t           dir_o,
    output gomoku_pkg::line_idx_t      idx_o,
    output logic                       last_o,
    output logic                       side_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SCAN,
        S_DRAIN
    } state_t;

    state_t                state_r;
    logic                  accept;
    gomoku_pkg::line_idx_t idx_max;

    // busy drops together with done so a start on the done cycle is taken
    assign busy_o  = (state_r != S_IDLE) && !done_i;
    assign accept  = start_i && !busy_o;
    assign load_o  = accept;
    assign issue_o = (state_r == S_SCAN);

    assign idx_max = (dir_o == gomoku_pkg::DIR_ROW || dir_o == gomoku_pkg::DIR_COL) ?
                     5'(gomoku_pkg::BOARD_SIZE - 1) : 5'(gomoku_pkg::DIAG_COUNT - 1);

    assign last_o = issue_o && (dir_o == gomoku_pkg::DIR_DIAG_DOWN_LEFT) && (idx_o == idx_max);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r <= S_IDLE;
            dir_o   <= gomoku_pkg::DIR_ROW;
            idx_o   <= '0;
            side_o  <= 1'b0;
        end else if (accept) begin
            state_r <= S_SCAN;
            dir_o   <= gomoku_pkg::DIR_ROW;
            idx_o   <= '0;
            side_o  <= turn_i;
        end else begin
            case (state_r)
                S_SCAN: begin
                    if (idx_o == idx_max) begin
                        idx_o <= '0;
                        if (last_o) begin
                            state_r <= S_DRAIN;
                        end else begin
                            dir_o <= gomoku_pkg::dir_t'(dir_o + 2'd1);
                        end
                    end else begin
                        idx_o <= idx_o + 5'd1;
                    end
                end
                // wait for the pipeline to empty
                S_DRAIN: begin
                    if (done_i) begin
                        state_r <= S_IDLE;
                    end
                end
                default: state_r <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/score_accumulator.sv */
// running black and white totals, final side-to-move score and the done pulse
`timescale 1ns/1ps
`default_nettype none

module score_accumulator (
    input  wire logic           i_clk,
    input  wire logic           i_rst_n,
    input  wire logic           load_i,
    input  wire logic           side_i,
    score_if.accum_mp           sif,
    output logic                done_o,
    output gomoku_pkg::score_t  score_o
);

    gomoku_pkg::score_t black_tot_r;
    gomoku_pkg::score_t white_tot_r;
    logic               last_seen_r;

    always_ff @(posedge i_clk) begin
        if (load_i) begin
            black_tot_r <= '0;
            white_tot_r <= '0;
        end else if (sif.valid) begin
            black_tot_r <= black_tot_r + sif.black_score;
            white_tot_r <= white_tot_r + sif.white_score;
        end
    end

    // totals are complete one cycle after the last line lands
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            last_seen_r <= 1'b0;
            done_o      <= 1'b0;
            score_o     <= '0;
        end else begin
            last_seen_r <= sif.valid && sif.last;
            done_o      <= last_seen_r;
            if (last_seen_r) begin
                score_o <= side_i ? (white_tot_r - black_tot_r) : (black_tot_r - white_tot_r);
            end
        end
    end

endmodule

`default_nettype wire

/* hw/score_if.sv */
// per-line black and white scores passed from the pattern matcher to the accumulator
`timescale 1ns/1ps
`default_nettype none

interface score_if;

    logic               valid;
    logic               last;
    gomoku_pkg::score_t black_score;
    gomoku_pkg::score_t white_score;

    modport matcher_mp (
        output valid, last, black_score, white_score
    );

    modport accum_mp (
        input valid, last, black_score, white_score
    );

endinterface

`default_nettype wire

/* testbench/eval_model.svh */
// reference scoring model and board builders, included into the evaluator testbench
`ifndef EVAL_MODEL_SVH
`define EVAL_MODEL_SVH

function automatic gomoku_pkg::cell_t cell_at(
    input gomoku_pkg::board_t b,
    input int                 r,
    input int                 c
);
    if (r < 0 || r >= gomoku_pkg::BOARD_SIZE || c < 0 || c >= gomoku_pkg::BOARD_SIZE) begin
        return gomoku_pkg::CELL_BORDER;
    end
    return b[r * gomoku_pkg::BOARD_SIZE + c];
endfunction

// dir 0 row, 1 column, 2 down-right, 3 down-left
function automatic gomoku_pkg::line_t model_line(
    input gomoku_pkg::board_t b,
    input int                 dir,
    input int                 idx
);
    int                r0;
    int                c0;
    int                dr;
    int                dc;
    int                rim;
    gomoku_pkg::line_t ln;

    rim = gomoku_pkg::BOARD_SIZE - 1;
    r0 = 0;
    c0 = 0;
    dr = 0;
    dc = 1;
    case (dir)
        0: r0 = idx;
        1: begin
            c0 = idx;
            dr = 1;
            dc = 0;
        end
        2: begin
            r0 = (rim - idx > 0) ? rim - idx : 0;
            c0 = (idx - rim > 0) ? idx - rim : 0;
            dr = 1;
        end
        default: begin
            r0 = (idx - rim > 0) ? idx - rim : 0;
            c0 = (idx < rim) ? idx : rim;
            dr = 1;
            dc = -1;
        end
    endcase
    ln[0] = gomoku_pkg::CELL_BORDER;
    ln[gomoku_pkg::LINE_CELLS-1] = gomoku_pkg::CELL_BORDER;
    for (int k = 0; k < gomoku_pkg::BOARD_SIZE; k++) begin
        ln[k+1] = cell_at(b, r0 + k * dr, c0 + k * dc);
    end
    return ln;
endfunction

function automatic bit run_of(
    input gomoku_pkg::line_t ln,
    input int                st,
    input int                n,
    input gomoku_pkg::cell_t c
);
    for (int k = 0; k < n; k++) begin
        if (ln[st+k] != c) begin
            return 1'b0;
        end
    end
    return 1'b1;
endfunction

function automatic gomoku_pkg::score_t side_score(
    input gomoku_pkg::line_t ln,
    input gomoku_pkg::cell_t c,
    input gomoku_pkg::cell_t o
);
    gomoku_pkg::score_t s;
    gomoku_pkg::cell_t  a;
    gomoku_pkg::cell_t  z;
    bit                 four;

    s = 0;
    for (int st = 0; st + 5 <= gomoku_pkg::LINE_CELLS; st++) begin
        if (run_of(ln, st, 5, c)) begin
            s += gomoku_pkg::DEF_W_FIVE;
        end
        if (ln[st] == gomoku_pkg::CELL_EMPTY && run_of(ln, st + 1, 3, c) &&
            ln[st+4] == gomoku_pkg::CELL_EMPTY) begin
            s += gomoku_pkg::DEF_W_OPEN_THREE;
        end
    end
    for (int st = 0; st + 6 <= gomoku_pkg::LINE_CELLS; st++) begin
        four = run_of(ln, st + 1, 4, c);
        a = ln[st];
        z = ln[st+5];
        if (four && a == gomoku_pkg::CELL_EMPTY && z == gomoku_pkg::CELL_EMPTY) begin
            s += gomoku_pkg::DEF_W_OPEN_FOUR;
        end
        if (four && ((a == gomoku_pkg::CELL_EMPTY && (z == o || z == gomoku_pkg::CELL_BORDER)) ||
                     (z == gomoku_pkg::CELL_EMPTY && (a == o || a == gomoku_pkg::CELL_BORDER)))) begin
            s += gomoku_pkg::DEF_W_BLOCKED_FOUR;
        end
    end
    return s;
endfunction

function automatic gomoku_pkg::score_t model_score(
    input gomoku_pkg::board_t b,
    input logic               turn
);
    gomoku_pkg::score_t blk;
    gomoku_pkg::score_t wht;
    gomoku_pkg::line_t  ln;
    int                 count;

    blk = 0;
    wht = 0;
    for (int dir = 0; dir < 4; dir++) begin
        count = (dir < 2) ? gomoku_pkg::BOARD_SIZE : 2 * gomoku_pkg::BOARD_SIZE - 1;
        for (int idx = 0; idx < count; idx++) begin
            ln = model_line(b, dir, idx);
            blk += side_score(ln, gomoku_pkg::CELL_BLACK, gomoku_pkg::CELL_WHITE);
            wht += side_score(ln, gomoku_pkg::CELL_WHITE, gomoku_pkg::CELL_BLACK);
        end
    end
    return turn ? (wht - blk) : (blk - wht);
endfunction

function automatic gomoku_pkg::board_t empty_board();
    gomoku_pkg::board_t b;

    for (int i = 0; i < gomoku_pkg::BOARD_CELLS; i++) begin
        b[i] = gomoku_pkg::CELL_EMPTY;
    end
    return b;
endfunction

function automatic gomoku_pkg::board_t place_run(
    input gomoku_pkg::board_t b,
    input int                 r,
    input int                 c,
    input int                 dr,
    input int                 dc,
    input int                 n,
    input gomoku_pkg::cell_t  stone
);
    for (int k = 0; k < n; k++) begin
        b[(r + k * dr) * gomoku_pkg::BOARD_SIZE + c + k * dc] = stone;
    end
    return b;
endfunction

// stones may land on the same cell, so the count is approximate
function automatic gomoku_pkg::board_t random_board(input int stones);
    gomoku_pkg::board_t b;
    int                 pos;

    b = empty_board();
    for (int i = 0; i < stones; i++) begin
        pos = $urandom_range(gomoku_pkg::BOARD_CELLS - 1);
        b[pos] = gomoku_pkg::cell_t'($urandom_range(1));
    end
    return b;
endfunction

`endif

/* testbench/tb_board_evaluator.sv */
// directed testbench for the gomoku board evaluator, run with the vlog.f file list
`timescale 1ns/1ps
`default_nettype none

module tb_board_evaluator;

    localparam int CLK_PERIOD = 10;
    localparam int LATENCY = gomoku_pkg::LINE_COUNT + 3;
    localparam int DONE_LIMIT = 2 * LATENCY;
    localparam int NUM_EVALS = 34;
    localparam int WATCHDOG_CYCLES = NUM_EVALS * 120 + 50;

    logic               clk;
    logic               rst_n;
    logic               start_in;
    gomoku_pkg::board_t board_in;
    logic               turn_in;
    logic               busy;
    logic               done;
    gomoku_pkg::score_t score;
    int                 cyc;
    int                 accept_cyc;
    int                 value_errors;
    int                 timeout_errors;

    `include "eval_model.svh"

    board_evaluator_top dut0 (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .start_i (start_in),
        .board_i (board_in),
        .turn_i  (turn_in),
        .busy_o  (busy),
        .done_o  (done),
        .score_o (score)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_score(input string sig, input gomoku_pkg::score_t exp,
                               input gomoku_pkg::score_t act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %0d, got %0d", $time, sig, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_done(input int measured, input int expected);
        if (measured != expected) begin
            $display("Fail at %0t: done_o latency expected %0d, got %0d",
                     $time, expected, measured);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string sig, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %b, got %b", $time, sig, exp, act);
            value_errors++;
        end
    endtask

    task automatic drive_start(input gomoku_pkg::board_t b, input logic t);
        @(posedge clk);
        board_in <= b;
        turn_in  <= t;
        start_in <= 1'b1;
    endtask

    // the edge that drops start is the accepting edge
    task automatic release_start();
        @(posedge clk);
        start_in <= 1'b0;
        @(negedge clk);
        accept_cyc = cyc;
        check_flag("busy_o", 1'b1, busy);
    endtask

    task automatic wait_done(output int latency, output bit seen);
        seen = 1'b0;
        for (int k = 0; k < DONE_LIMIT && !seen; k++) begin
            @(negedge clk);
            seen = done;
        end
        latency = cyc - accept_cyc;
        if (!seen) begin
            $display("No done pulse arrived within %0d cycles of the start at %0t",
                     DONE_LIMIT, $time);
            timeout_errors++;
        end
    endtask

    task automatic evaluate(input gomoku_pkg::board_t b, input logic t,
                            input gomoku_pkg::score_t exp, input bit poke);
        int lat;
        bit seen;

        drive_start(b, t);
        release_start();
        if (poke) begin
            // a start during the scan must be ignored
            repeat (10) @(posedge clk);
            start_in <= 1'b1;
            board_in <= place_run(empty_board(), 7, 3, 0, 1, 5, gomoku_pkg::CELL_BLACK);
            turn_in  <= ~t;
            @(posedge clk);
            start_in <= 1'b0;
        end
        wait_done(lat, seen);
        if (seen) begin
            check_done(lat, LATENCY);
            check_score("score_o", exp, score);
        end
        @(negedge clk);
        check_flag("done_o", 1'b0, done);
        check_flag("busy_o", 1'b0, busy);
        check_score("score_o", exp, score);
    endtask

    task automatic test_reset_and_empty();
        @(negedge clk);
        check_flag("busy_o", 1'b0, busy);
        check_flag("done_o", 1'b0, done);
        check_score("score_o", 0, score);
        evaluate(empty_board(), 1'b0, 0, 1'b0);
    endtask

    task automatic test_five_in_row();
        gomoku_pkg::board_t b;

        b = place_run(empty_board(), 7, 3, 0, 1, 5, gomoku_pkg::CELL_BLACK);
        evaluate(b, 1'b0, gomoku_pkg::DEF_W_FIVE, 1'b0);
        evaluate(b, 1'b1, -gomoku_pkg::DEF_W_FIVE, 1'b0);
    endtask

    // fours then threes, one per direction, some against the edge
    task automatic test_edge_patterns();
        int                 rs[8] = '{4, 0, 3, 2, 14, 6, 10, 0};
        int                 cs[8] = '{5, 6, 3, 12, 0, 9, 1, 14};
        int                 drs[8] = '{0, 1, 1, 1, 0, 1, 1, 1};
        int                 dcs[8] = '{1, 0, 1, -1, 1, 0, 1, -1};
        gomoku_pkg::board_t b;
        gomoku_pkg::cell_t  stone;
        logic               t;

        for (int i = 0; i < 8; i++) begin
            stone = (i % 2 == 0) ? gomoku_pkg::CELL_BLACK : gomoku_pkg::CELL_WHITE;
            t = logic'(i % 2);
            b = place_run(empty_board(), rs[i], cs[i], drs[i], dcs[i], (i < 4) ? 4 : 3, stone);
            evaluate(b, t, model_score(b, t), 1'b0);
        end
    endtask

    task automatic test_capped_four();
        gomoku_pkg::board_t b;

        b = place_run(empty_board(), 9, 4, 0, 1, 4, gomoku_pkg::CELL_WHITE);
        b = place_run(b, 9, 3, 0, 1, 1, gomoku_pkg::CELL_BLACK);
        evaluate(b, 1'b0, model_score(b, 1'b0), 1'b0);
    endtask

    task automatic test_random_boards();
        gomoku_pkg::board_t b;
        logic               t;

        for (int i = 0; i < 20; i++) begin
            b = random_board(30);
            t = logic'($urandom_range(1));
            evaluate(b, t, model_score(b, t), i == 7);
        end
    endtask

    task automatic test_back_to_back();
        gomoku_pkg::board_t b1;
        gomoku_pkg::board_t b2;
        int                 lat;
        bit                 seen;

        b1 = random_board(30);
        b2 = random_board(30);
        drive_start(b1, 1'b0);
        release_start();
        // second request is held and taken when busy drops on the done cycle
        @(posedge clk);
        start_in <= 1'b1;
        board_in <= b2;
        turn_in  <= 1'b1;
        wait_done(lat, seen);
        if (seen) begin
            check_done(lat, LATENCY);
            check_score("score_o", model_score(b1, 1'b0), score);
            check_flag("busy_o", 1'b0, busy);
        end
        release_start();
        wait_done(lat, seen);
        if (seen) begin
            check_done(lat, LATENCY);
            check_score("score_o", model_score(b2, 1'b1), score);
        end
        @(negedge clk);
        check_flag("done_o", 1'b0, done);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        start_in = 1'b0;
        board_in = empty_board();
        turn_in = 1'b0;
        cyc = 0;
        accept_cyc = 0;
        value_errors = 0;
        timeout_errors = 0;
        void'($urandom(32'h4268));
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        test_reset_and_empty();
        test_five_in_row();
        test_edge_patterns();
        test_capped_four();
        test_random_boards();
        test_back_to_back();

        $display("errors: %0d wrong values, %0d missing done pulses",
                 value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d clock cycles, the run did not finish",
                 WATCHDOG_CYCLES);
        $display("errors: %0d wrong values, %0d missing done pulses",
                 value_errors, timeout_errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+testbench
hw/gomoku_pkg.sv
hw/score_if.sv
hw/scan_controller.sv
hw/board_line_reader.sv
hw/line_pattern_matcher.sv
hw/score_accumulator.sv
hw/board_evaluator_top.sv
testbench/tb_board_evaluator.sv
